//--- sram_cfg_pkg.sv
package sram_cfg_pkg;

    // single bank, 2048 words of 128 bits
    localparam int mem_depth  = 2048;
    localparam int mem_addr_w = $clog2(mem_depth);  // 11 bits
    localparam int mem_data_w = 128;

    // word address into the bank
    typedef logic [mem_addr_w-1:0] mem_addr_t;

    // one memory word
    typedef logic [mem_data_w-1:0] mem_data_t;

endpackage

//--- wr_port_pkg.sv
package wr_port_pkg;

    import sram_cfg_pkg::*;

    // write ports sharing the bank
    localparam int port_num   = 16;
    localparam int port_idx_w = $clog2(port_num);  // 4 bits

    // rotation pointer after reset
    localparam int rr_init = 13;

    typedef logic [port_idx_w-1:0] port_idx_t;

    // one bit per port, bit p belongs to port p
    typedef logic [port_num-1:0] port_vec_t;

    // one write beat as a port drives it, 140 bits
    typedef struct packed {
        mem_addr_t addr;
        mem_data_t data;
        logic      wen;   // beat is written only when set
    } wr_beat_t;

endpackage

//--- port_arbiter.sv
`timescale 1ns/100ps

module port_arbiter
    import wr_port_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,

    input  port_vec_t i_wr_req,
    input  port_vec_t i_wr_done,

    output port_vec_t o_wr_grant,
    output port_vec_t o_wr_refuse,
    output port_idx_t o_sel,
    output logic      o_busy
);

    // one-hot state codes
    typedef enum logic [2:0] {
        s_idle  = 3'b001,
        s_arbi  = 3'b010,
        s_write = 3'b100
    } state_t;

    state_t    state;
    state_t    state_nxt;

    port_idx_t rr_ptr;     // search starts here
    port_idx_t sel_q;
    port_idx_t sel_nxt;

    port_idx_t pick;
    logic      pick_vld;

    port_vec_t grant_q;
    port_vec_t refuse_q;
    port_vec_t grant_nxt;

    // first requester at or after the pointer, wrapping past 15
    always_comb begin : rr_search
        port_idx_t idx;
        pick     = rr_ptr;
        pick_vld = 1'b0;
        for (int i = 0; i < port_num; i++) begin
            idx = rr_ptr + port_idx_t'(i);   // 4-bit add wraps
            if (!pick_vld && i_wr_req[idx]) begin
                pick     = idx;
                pick_vld = 1'b1;
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            s_idle: begin
                if (|i_wr_req) begin
                    state_nxt = s_arbi;
                end
            end
            s_arbi: begin
                // requests are held until granted, idle is only a fallback
                state_nxt = pick_vld ? s_write : s_idle;
            end
            s_write: begin
                if (i_wr_done[sel_q]) begin   // only the owner's done counts
                    state_nxt = s_idle;
                end
            end
            default: state_nxt = s_idle;
        endcase
    end

    assign sel_nxt   = (state == s_arbi) ? pick : sel_q;
    assign grant_nxt = (state_nxt == s_write) ? (port_vec_t'(1) << sel_nxt) : '0;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= s_idle;
            rr_ptr   <= port_idx_t'(rr_init);
            sel_q    <= '0;
            grant_q  <= '0;
            refuse_q <= '0;
        end else begin
            state <= state_nxt;
            if (state == s_arbi && pick_vld) begin
                sel_q  <= pick;
                rr_ptr <= rr_ptr + 1'b1;   // advances whoever wins
            end
            grant_q  <= grant_nxt;
            // zero whenever grant is zero
            refuse_q <= (state_nxt == s_write) ? (i_wr_req & ~grant_nxt) : '0;
        end
    end

    assign o_wr_grant  = grant_q;
    assign o_wr_refuse = refuse_q;
    assign o_sel       = sel_q;
    assign o_busy      = (state == s_write);

endmodule

//--- write_path.sv
`timescale 1ns/100ps

module write_path
    import sram_cfg_pkg::*;
    import wr_port_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,

    input  wr_beat_t  i_beats [port_num],
    input  port_idx_t i_sel,
    input  logic      i_busy,

    output wr_beat_t  o_mem_wr
);

    wr_beat_t  beat_sel;

    mem_addr_t addr_q;
    mem_data_t data_q;
    logic      wen_q;

    // granted port's beat
    assign beat_sel = i_beats[i_sel];

    // write enable, forced low outside a grant
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wen_q <= 1'b0;
        end else begin
            wen_q <= i_busy & beat_sel.wen;
        end
    end

    // payload only, qualified by wen_q downstream
    always_ff @(posedge i_clk) begin
        if (i_busy) begin
            addr_q <= beat_sel.addr;
            data_q <= beat_sel.data;
        end
    end

    assign o_mem_wr = '{addr: addr_q, data: data_q, wen: wen_q};

endmodule

//--- sram_bank.sv
`timescale 1ns/100ps

module sram_bank
    import sram_cfg_pkg::*;
    import wr_port_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,

    input  wr_beat_t  i_mem_wr,

    input  mem_addr_t i_rd_addr,
    output mem_data_t o_rd_data
);

    mem_data_t mem [mem_depth];

    // synchronous write port
    always_ff @(posedge i_clk) begin
        if (i_mem_wr.wen) begin
            mem[i_mem_wr.addr] <= i_mem_wr.data;
        end
    end

    // one cycle read, old word on a same-edge collision
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rd_data <= '0;
        end else begin
            o_rd_data <= mem[i_rd_addr];
        end
    end

endmodule

//--- sram_ctor.sv
`timescale 1ns/100ps

module sram_ctor
    import sram_cfg_pkg::*;
    import wr_port_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,

    // sixteen write ports
    input  port_vec_t i_wr_req,
    input  wr_beat_t  i_wr_beat [port_num],
    input  port_vec_t i_wr_done,
    output port_vec_t o_wr_grant,
    output port_vec_t o_wr_refuse,

    // read port
    input  mem_addr_t i_rd_addr,
    output mem_data_t o_rd_data
);

    port_idx_t sel;
    logic      busy;     // high while a port owns the bank
    wr_beat_t  mem_wr;

    port_arbiter u_arbiter (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_wr_req    (i_wr_req),
        .i_wr_done   (i_wr_done),
        .o_wr_grant  (o_wr_grant),
        .o_wr_refuse (o_wr_refuse),
        .o_sel       (sel),
        .o_busy      (busy)
    );

    write_path u_write_path (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_beats  (i_wr_beat),
        .i_sel    (sel),
        .i_busy   (busy),
        .o_mem_wr (mem_wr)
    );

    // bank writes one edge after the beat is registered
    sram_bank u_bank (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_mem_wr  (mem_wr),
        .i_rd_addr (i_rd_addr),
        .o_rd_data (o_rd_data)
    );

endmodule

//--- tb_sram_ctor_assertions.sv
`timescale 1ns/100ps

module tb_sram_ctor_assertions
    import wr_port_pkg::*;
(
    input logic      i_clk,
    input logic      i_rst_n,
    input port_vec_t i_wr_done,
    input port_vec_t i_wr_grant,
    input port_vec_t i_wr_refuse
);

    // at most one owner of the bank
    grant_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot0(i_wr_grant))
        else $error("grant has more than one bit set");

    // refuse only while someone else owns the bank
    refuse_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_wr_grant & i_wr_refuse) == '0 && (i_wr_grant != '0 || i_wr_refuse == '0))
        else $error("refuse set for the granted port or outside a grant");

    // owner keeps the grant until its own done is sampled
    grant_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_wr_grant != '0 && (i_wr_grant & i_wr_done) == '0)
            |=> i_wr_grant == $past(i_wr_grant))
        else $error("grant changed before done");

    grant_release: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_wr_grant & i_wr_done) != '0 |=> i_wr_grant == '0)
        else $error("grant still set after done");

endmodule

bind port_arbiter tb_sram_ctor_assertions u_assertions (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_wr_done   (i_wr_done),
    .i_wr_grant  (o_wr_grant),
    .i_wr_refuse (o_wr_refuse)
);

//--- tb_sram_ctor.sv
`timescale 1ns/100ps

module tb_sram_ctor
    import sram_cfg_pkg::*;
    import wr_port_pkg::*;
();

    logic      clk = 1'b0;
    logic      rst_n;
    port_vec_t wr_req;
    wr_beat_t  wr_beat [port_num];
    port_vec_t wr_done;
    port_vec_t grant;
    port_vec_t refuse;
    mem_addr_t rd_addr;
    mem_data_t rd_data;

    // trace commands, one entry per line
    logic [7:0] cmd_op   [$];
    port_vec_t  cmd_mask [$];
    mem_addr_t  cmd_addr [$];
    mem_data_t  cmd_seed [$];
    int         cmd_cnt  [$];

    mem_data_t model_mem [mem_depth];
    port_idx_t model_ptr = port_idx_t'(rr_init);

    int errors = 0;
    int checks = 0;
    int n_tests = 0;
    int n_failed = 0;
    int cycles = 0;
    int cycle_limit = 1000;

    sram_ctor i_dut (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_wr_req    (wr_req),
        .i_wr_beat   (wr_beat),
        .i_wr_done   (wr_done),
        .o_wr_grant  (grant),
        .o_wr_refuse (refuse),
        .i_rd_addr   (rd_addr),
        .o_rd_data   (rd_data)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("simulation stopped, cycle limit %0d reached", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic expect_ports(port_vec_t got, port_vec_t exp, string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic verify_word(mem_data_t got, mem_data_t exp, string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // first requester at or after ptr, scanned backwards so the nearest one wins
    function automatic port_idx_t rr_pick(port_vec_t req, port_idx_t ptr);
        port_idx_t idx;
        rr_pick = ptr;
        for (int i = port_num - 1; i >= 0; i--) begin
            idx = ptr + port_idx_t'(i);
            if (req[idx]) begin
                rr_pick = idx;
            end
        end
    endfunction

    function automatic wr_beat_t make_beat(int p, int b, mem_addr_t base, mem_data_t seed);
        wr_beat_t bt;
        bt.addr = base + mem_addr_t'(p * 64 + b);   // wraps at the top of the bank
        bt.data = seed + mem_data_t'(p + b);
        bt.wen  = (b % 4 != 3);                     // every fourth beat skipped
        return bt;
    endfunction

    task automatic load_trace();
        int         fd;
        int         n;
        string      line;
        logic [7:0] op;
        port_vec_t  mask;
        mem_addr_t  addr;
        mem_data_t  seed;
        int         cnt;
        fd = $fopen("sram_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open sram_trace.txt for reading");
        end else begin
            while ($fgets(line, fd) != 0) begin
                op = 8'h00;
                n  = $sscanf(line, "%c", op);
                if (op == "W") begin
                    n = $sscanf(line, "%c %h %h %h %d", op, mask, addr, seed, cnt);
                end else if (op == "R") begin
                    n = $sscanf(line, "%c %h", op, addr);
                    mask = '0;
                    seed = '0;
                    cnt  = 0;
                end
                if ((op == "W" && n == 5) || (op == "R" && n == 2)) begin
                    cmd_op.push_back(op);
                    cmd_mask.push_back(mask);
                    cmd_addr.push_back(addr);
                    cmd_seed.push_back(seed);
                    cmd_cnt.push_back(cnt);
                end else if (op == "W" || op == "R") begin
                    $display("malformed command in sram_trace.txt: %s", line);
                    errors++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic reset_dut();
        rst_n = 1'b0;
        repeat (8) @(negedge clk);
        expect_ports(grant, '0, "grant in reset");
        expect_ports(refuse, '0, "refuse in reset");
        verify_word(rd_data, '0, "read data in reset");
        rst_n = 1'b1;
    endtask

    // all ports in mask apply together, each writes count beats once granted
    task automatic run_group(port_vec_t mask, mem_addr_t base, mem_data_t seed, int count);
        port_vec_t onehot;
        port_idx_t win;
        int        waited;
        wr_beat_t  bt;
        wr_req = mask;
        while (wr_req != '0) begin
            waited = 0;
            while (grant == '0 && waited < 8) begin
                @(negedge clk);
                waited++;
            end
            win       = rr_pick(wr_req, model_ptr);
            model_ptr = model_ptr + 1'b1;
            onehot    = port_vec_t'(1) << win;
            checks++;
            assert (waited == 2) else begin
                errors++;
                $display("error %0t: grant after %0d cycles, expected 2", $time, waited);
            end
            for (int b = 0; b < count; b++) begin
                expect_ports(grant, onehot, "grant");
                expect_ports(refuse, wr_req & ~onehot, "refuse");
                bt = make_beat(win, b, base, seed);
                wr_beat[win] = bt;
                wr_done[win] = (b == count - 1);   // done rides on the last beat
                if (bt.wen) begin
                    model_mem[bt.addr] = bt.data;
                end
                @(negedge clk);
            end
            expect_ports(grant, '0, "grant after done");
            expect_ports(refuse, '0, "refuse after done");
            wr_req[win]  = 1'b0;
            wr_done[win] = 1'b0;
            wr_beat[win] = '0;
        end
    endtask

    task automatic read_word(mem_addr_t addr);
        rd_addr = addr;
        @(negedge clk);
        verify_word(rd_data, model_mem[addr], $sformatf("read at %h", addr));
    endtask

    task automatic close_test(string label, int errs_before);
        n_tests++;
        if (errors != errs_before) begin
            n_failed++;
        end
        $display("test %0d %s: %s", n_tests, label, (errors == errs_before) ? "ok" : "fail");
    endtask

    initial begin
        int errs_before;
        int gap;
        void'($urandom(32'hb337));
        rst_n   = 1'b0;
        wr_req  = '0;
        wr_done = '0;
        rd_addr = '0;
        for (int p = 0; p < port_num; p++) begin
            wr_beat[p] = '0;
        end
        load_trace();
        cycle_limit = 40 * cmd_op.size() + 200;
        errs_before = errors;
        reset_dut();
        close_test("reset", errs_before);
        if (cmd_op.size() == 0) begin
            $display("no commands found in sram_trace.txt");
            errors++;
        end
        foreach (cmd_op[i]) begin
            errs_before = errors;
            if (cmd_op[i] == "W") begin
                run_group(cmd_mask[i], cmd_addr[i], cmd_seed[i], cmd_cnt[i]);
                @(negedge clk);   // last registered beat lands in the bank
                gap = int'($urandom_range(3, 0));
                repeat (gap) @(negedge clk);
                close_test($sformatf("write mask %h", cmd_mask[i]), errs_before);
            end else begin
                read_word(cmd_addr[i]);
                close_test($sformatf("read %h", cmd_addr[i]), errs_before);
            end
        end
        $display("%0d tests, %0d failed, %0d of %0d checks wrong",
                 n_tests, n_failed, errors, checks);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- sram_trace.txt
# W <port mask hex> <base addr hex> <data seed hex> <beats per port, decimal>
# R <read addr hex>
W 0001 000 00000000000000000000000000001000 4
R 000
R 001
R 002
R 003
W ffff 000 a5a5a5a5a5a5a5a50000000000000000 5
R 000
R 003
R 040
R 384
R 3c4
W 0001 000 11111111222222223333333344444440 4
R 000
R 002
R 003
R 004
W a5a5 100 deadbeefdeadbeefdeadbeef00000000 6
R 100
R 105
R 243
R 4c5
W 8002 7f0 fffffffffffffffffffffffffffffff8 5
R 030
R 3b0
R 3b4
W 2000 200 0123456789abcdef0123456789abcdef 4
W 6000 200 00000000000000000000000000abcd00 4
R 541
R 583

//--- all.f
sram_cfg_pkg.sv
wr_port_pkg.sv
port_arbiter.sv
write_path.sv
sram_bank.sv
sram_ctor.sv
tb_sram_ctor_assertions.sv
tb_sram_ctor.sv

//--- run.sh
#!/usr/bin/env bash
# compile with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f all.f --top-module tb_sram_ctor \
    --Mdir obj_dir -o tb_sram_ctor_sim \
    && ./obj_dir/tb_sram_ctor_sim | tee sim.log \
    || { echo "build or run failed"; exit 1; }

grep -q "TEST PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
